// ==== testbench/decode_stimulus.txt ====
# S addr data | V addr data | B pairs the next issue with the write before it
# I instruction s1 s2 swb v1 v2 vwb (hex, expected addresses)
I 40A33800 03 07 05 0 0 0
S 03 DEADBEEF
S 07 12345678
S 00 FFFFFFFF
V 02 0123456789ABCDEF0011223344556677
V 05 FEDCBA9876543210AABBCCDDEEFF0011
V 00 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
I 40A33800 03 07 05 0 0 0
I 51201800 00 03 00 0 0 0
I 00C22800 00 00 00 2 5 6
I 10728000 00 00 00 2 0 0
I 20851800 00 03 00 5 0 4
I 33E71800 07 03 1F 0 0 0
I 80A33800 03 00 05 0 0 0
I 95020000 00 00 08 2 0 0
I 98470000 07 00 02 0 0 0
I 9CA30000 03 00 00 5 0 5
I B8C70000 07 00 00 0 0 6
I B1230000 03 00 09 0 0 0
I C0A30000 00 00 00 0 0 0
I FC470000 07 00 00 2 0 0
I F0E30000 03 07 00 0 0 0
S 03 CAFEF00D
B
I 40A33800 03 07 05 0 0 0
V 05 00000000111111112222222233333333
B
I 00C22800 00 00 00 2 5 6
S 00 55555555
B
I 51201800 00 03 00 0 0 0

// ==== tb.f ====
+incdir+common
common/isa_pkg.sv
common/operand_pkg.sv
address_decode/address_decode_unit.sv
register_file/register_file.sv
logic/decode_stage.sv
testbench/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module decode_stage_tb \
    -Mdir obj_dir -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/decode_stage_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/decode_stage_tb.sv ====
`default_nettype none

`include "decode_defines.svh"

module decode_stage_tb;

    import isa_pkg::*;
    import operand_pkg::*;

    localparam int VALID_TIMEOUT = 20;
    localparam int RUN_LIMIT     = 2000;

    // One record of the stimulus file
    typedef struct packed {
        logic [7:0]    kind;
        logic [15:0]   line_no;
        instr_t        instr;
        logic [4:0]    addr;
        vdata_t        data;
        operand_addr_s addrs;
    } record_s;

    // Output expected at a given falling edge
    typedef struct packed {
        logic [31:0] due;
        logic [15:0] line_no;
        decode_out_s out;
    } expect_s;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instruction;
    sreg_write_s s_write;
    vreg_write_s v_write;
    decode_out_s decode_out;

    sdata_t      s_model [`SREG_COUNT];
    vdata_t      v_model [`VREG_COUNT];
    record_s     records [$];
    expect_s     expected [$];
    decode_out_s held_out;
    int          pass_count;
    int          fail_count;
    logic [31:0] neg_count;

    decode_stage dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .s_write     (s_write),
        .v_write     (v_write),
        .decode_out  (decode_out)
    );

    always #20 clk = ~clk;

    function automatic string addr_text(input operand_addr_s a);
        return $sformatf("s1=%h s2=%h swb=%h v1=%h v2=%h vwb=%h",
                         a.s1, a.s2, a.swb, a.v1, a.v2, a.vwb);
    endfunction

    function automatic sreg_write_s scalar_bus(input record_s rec);
        sreg_write_s bus;
        bus = '0;
        if (rec.kind == "S") begin
            bus.en   = 1'b1;
            bus.addr = rec.addr;
            bus.data = rec.data[`XLEN-1:0];
        end
        return bus;
    endfunction

    function automatic vreg_write_s vector_bus(input record_s rec);
        vreg_write_s bus;
        bus = '0;
        if (rec.kind == "V") begin
            bus.en   = 1'b1;
            bus.addr = rec.addr[3:0];
            bus.data = rec.data;
        end
        return bus;
    endfunction

    task automatic parse_line(input logic [8*200-1:0] text, input int line_no);
        logic [63:0] tok;
        record_s     rec;
        instr_t      instr;
        logic [4:0]  addr;
        vdata_t      data;
        sreg_addr_t  s1;
        sreg_addr_t  s2;
        sreg_addr_t  swb;
        vreg_addr_t  v1;
        vreg_addr_t  v2;
        vreg_addr_t  vwb;
        int          code;
        tok = '0;
        rec = '0;
        rec.line_no = line_no[15:0];
        code = $sscanf(text, "%s", tok);
        if (code == 1 && tok[7:0] != "#") begin
            rec.kind = tok[7:0];
            case (tok[7:0])
                "S", "V": begin
                    code = $sscanf(text, "%s %h %h", tok, addr, data);
                    rec.addr = addr;
                    rec.data = data;
                end
                "I": begin
                    code = $sscanf(text, "%s %h %h %h %h %h %h %h",
                                   tok, instr, s1, s2, swb, v1, v2, vwb);
                    rec.instr = instr;
                    rec.addrs = '{s1: s1, s2: s2, swb: swb, v1: v1, v2: v2, vwb: vwb};
                    code = (code == 8) ? 3 : 0;
                end
                "B": code = 3;
                default: code = 0;
            endcase
            if (code == 3) begin
                records.push_back(rec);
            end else begin
                $display("Line %0d of the stimulus file could not be read", line_no);
                fail_count++;
            end
        end
    endtask

    task automatic load_records();
        logic [8*200-1:0] text;
        int               fd;
        int               line_no;
        fd = $fopen("testbench/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/decode_stimulus.txt");
            fail_count++;
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                text = '0;
                line_no++;
                if ($fgets(text, fd) > 0) begin
                    parse_line(text, line_no);
                end
            end
            $fclose(fd);
        end
        if (records.size() == 0) begin
            $display("The stimulus file holds no records");
            fail_count++;
        end
    endtask

    task automatic drive_cycle(input logic valid, input instr_t instr,
                               input sreg_write_s sw, input vreg_write_s vw);
        @(posedge clk);
        instr_valid <= valid;
        instruction <= instr;
        s_write     <= sw;
        v_write     <= vw;
    endtask

    // Register 0 never changes in the model
    task automatic apply_write(input record_s rec);
        if (rec.kind == "S" && rec.addr != 5'd0) begin
            s_model[rec.addr] = rec.data[`XLEN-1:0];
        end
        if (rec.kind == "V" && rec.addr[3:0] != 4'd0) begin
            v_model[rec.addr[3:0]] = rec.data;
        end
    endtask

    task automatic issue_cycle(input record_s rec, input record_s wr);
        expect_s exp;
        exp = '0;
        exp.line_no     = rec.line_no;
        exp.out.valid   = 1'b1;
        exp.out.addrs   = rec.addrs;
        exp.out.s1_data = s_model[rec.addrs.s1];
        exp.out.s2_data = s_model[rec.addrs.s2];
        exp.out.v1_data = v_model[rec.addrs.v1];
        exp.out.v2_data = v_model[rec.addrs.v2];
        drive_cycle(1'b1, rec.instr, scalar_bus(wr), vector_bus(wr));
        // Captured at the next rising edge, seen at the falling edge after it
        exp.due = neg_count + 2;
        expected.push_back(exp);
    endtask

    task automatic run_records();
        record_s rec;
        int      i;
        int      idle;
        logic    paired;
        i = 0;
        while (i < records.size()) begin
            rec = records[i];
            paired = (i + 2 < records.size()) && (records[i+1].kind == "B")
                     && (records[i+2].kind == "I");
            if (rec.kind == "S" || rec.kind == "V") begin
                apply_write(rec);
                if (paired) begin
                    issue_cycle(records[i+2], rec);
                    i = i + 3;
                end else begin
                    drive_cycle(1'b0, $urandom, scalar_bus(rec), vector_bus(rec));
                    i = i + 1;
                end
            end else if (rec.kind == "I") begin
                issue_cycle(rec, '0);
                i = i + 1;
            end else begin
                $display("Line %0d has a B record without a write and issue", rec.line_no);
                fail_count++;
                i = i + 1;
            end
            // Random idle instructions unless another issue follows
            if ((rec.kind == "I" || paired)
                && (i >= records.size() || records[i].kind != "I")) begin
                idle = 1 + int'($urandom % 3);
                repeat (idle) drive_cycle(1'b0, $urandom, '0, '0);
            end
        end
    endtask

    task automatic compare_output(input expect_s exp);
        string name;
        int    errors;
        name = $sformatf("issue_line%0d", exp.line_no);
        errors = 0;
        if (exp.due != neg_count) begin
            $display("Test %s: valid rose at the wrong edge", name);
            errors++;
        end
        if (decode_out.addrs !== exp.out.addrs) begin
            $display("Mismatch %s addrs: expected %s, actual %s", name,
                     addr_text(exp.out.addrs), addr_text(decode_out.addrs));
            errors++;
        end
        if (decode_out.s1_data !== exp.out.s1_data) begin
            $display("Mismatch %s s1_data: expected %h, actual %h", name,
                     exp.out.s1_data, decode_out.s1_data);
            errors++;
        end
        if (decode_out.s2_data !== exp.out.s2_data) begin
            $display("Mismatch %s s2_data: expected %h, actual %h", name,
                     exp.out.s2_data, decode_out.s2_data);
            errors++;
        end
        if (decode_out.v1_data !== exp.out.v1_data) begin
            $display("Mismatch %s v1_data: expected %h, actual %h", name,
                     exp.out.v1_data, decode_out.v1_data);
            errors++;
        end
        if (decode_out.v2_data !== exp.out.v2_data) begin
            $display("Mismatch %s v2_data: expected %h, actual %h", name,
                     exp.out.v2_data, decode_out.v2_data);
            errors++;
        end
        if (errors == 0) begin
            $display("Test %s: ok", name);
            pass_count++;
        end else begin
            $display("Test %s: failed", name);
            fail_count++;
        end
    endtask

    // Payload keeps the last issue while valid is low
    task automatic check_hold();
        if (decode_out !== held_out) begin
            $display("Mismatch idle_hold: expected %h, actual %h", held_out, decode_out);
            fail_count++;
        end
    endtask

    task automatic check_output();
        expect_s head;
        if (rst_n && decode_out.valid) begin
            if (expected.size() == 0) begin
                $display("decode_out.valid was high with no instruction issued");
                fail_count++;
            end else begin
                head = expected.pop_front();
                compare_output(head);
                held_out = head.out;
                held_out.valid = 1'b0;
            end
        end else if (rst_n) begin
            if (expected.size() > 0 && expected[0].due <= neg_count) begin
                head = expected.pop_front();
                $display("Test issue_line%0d: valid did not rise one edge after the issue",
                         head.line_no);
                fail_count++;
            end
            check_hold();
        end
    endtask

    task automatic check_reset();
        @(negedge clk);
        if (decode_out.valid !== 1'b0) begin
            $display("Mismatch reset valid: expected 0, actual %b", decode_out.valid);
            fail_count++;
        end else if (decode_out !== '0) begin
            $display("Mismatch reset decode_out: expected 0, actual %h", decode_out);
            fail_count++;
        end else begin
            $display("Test reset: ok");
            pass_count++;
        end
    endtask

    task automatic wait_for_outputs();
        int cycles;
        cycles = 0;
        while (expected.size() > 0 && cycles < VALID_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() > 0) begin
            $display("Timed out waiting for decode_out.valid with %0d issues outstanding",
                     expected.size());
            fail_count++;
        end
    endtask

    // Output monitor
    initial begin
        neg_count = '0;
        held_out = '0;
        forever begin
            @(negedge clk);
            neg_count = neg_count + 1;
            check_output();
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run stopped after %0d cycles without finishing", RUN_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(43377));
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        s_write = '0;
        v_write = '0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < `SREG_COUNT; i++) begin
            s_model[i] = '0;
        end
        for (int i = 0; i < `VREG_COUNT; i++) begin
            v_model[i] = '0;
        end
        load_records();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        run_records();
        wait_for_outputs();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

`include "decode_defines.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  isa_pkg::instr_t          instruction,
    input  operand_pkg::sreg_write_s s_write,
    input  operand_pkg::vreg_write_s v_write,
    output operand_pkg::decode_out_s decode_out
);

    import isa_pkg::*;
    import operand_pkg::*;

    operand_addr_s addrs;
    sdata_t        s1_data;
    sdata_t        s2_data;
    vdata_t        v1_data;
    vdata_t        v2_data;

    address_decode_unit addr_dec_i (
        .instruction (instruction),
        .addrs       (addrs)
    );

    // Scalar operands
    register_file #(
        .DEPTH (`SREG_COUNT),
        .WIDTH (`XLEN)
    ) scalar_rf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (addrs.s1),
        .rd_addr_b (addrs.s2),
        .rd_data_a (s1_data),
        .rd_data_b (s2_data),
        .wr_en     (s_write.en),
        .wr_addr   (s_write.addr),
        .wr_data   (s_write.data)
    );

    // Vector operands, all lanes read together
    register_file #(
        .DEPTH (`VREG_COUNT),
        .WIDTH (`VLEN)
    ) vector_rf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (addrs.v1),
        .rd_addr_b (addrs.v2),
        .rd_data_a (v1_data),
        .rd_data_b (v2_data),
        .wr_en     (v_write.en),
        .wr_addr   (v_write.addr),
        .wr_data   (v_write.data)
    );

    // Output register, payload holds when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_out <= '0;
        end else if (instr_valid) begin
            decode_out.valid   <= 1'b1;
            decode_out.addrs   <= addrs;
            decode_out.s1_data <= s1_data;
            decode_out.s2_data <= s2_data;
            decode_out.v1_data <= v1_data;
            decode_out.v2_data <= v2_data;
        end else begin
            decode_out.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== register_file/register_file.sv ====
`default_nettype none

`include "decode_defines.svh"

module register_file #(
    parameter int DEPTH = `SREG_COUNT,
    parameter int WIDTH = `XLEN
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_a,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_b,
    output logic [WIDTH-1:0]         rd_data_a,
    output logic [WIDTH-1:0]         rd_data_b,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Zero register first, then bypass, then storage
    function automatic logic [WIDTH-1:0] read_port(
        input logic [$clog2(DEPTH)-1:0] addr
    );
        logic [WIDTH-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && (addr == wr_addr)) begin
            value = wr_data;
        end else begin
            value = mem[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
    end

    always_comb begin
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

`default_nettype wire

// ==== address_decode/address_decode_unit.sv ====
`default_nettype none

module address_decode_unit (
    input  isa_pkg::instr_t        instruction,
    output isa_pkg::operand_addr_s addrs
);

    import isa_pkg::*;

    always_comb begin
        if (instruction[31] == 1'b0) begin
            // Register mode, start from the full field set
            addrs.s1  = instruction[20:16];
            addrs.s2  = instruction[15:11];
            addrs.swb = instruction[25:21];
            addrs.v1  = instruction[19:16];
            addrs.v2  = instruction[14:11];
            addrs.vwb = instruction[24:21];

            if (instruction[30:29] == 2'b00) begin
                // VV
                addrs.s1  = SREG_NONE;
                addrs.s2  = SREG_NONE;
                addrs.swb = SREG_NONE;
                if (instruction[28] == 1'b1) begin
                    addrs.vwb = VREG_NONE;
                end
            end else if (instruction[30:28] == 3'b010) begin
                // VF, scalar operand on s2 only
                addrs.s1  = SREG_NONE;
                addrs.v2  = VREG_NONE;
                addrs.swb = SREG_NONE;
            end else if (instruction[30:28] == 3'b011) begin
                // NAOX
                addrs.v1  = VREG_NONE;
                addrs.v2  = VREG_NONE;
                addrs.vwb = VREG_NONE;
            end else begin
                // Int and float
                addrs.v1  = VREG_NONE;
                addrs.v2  = VREG_NONE;
                addrs.vwb = VREG_NONE;
                if (instruction[28] == 1'b1) begin
                    addrs.swb = SREG_NONE;
                end
            end
        end else begin
            // Immediate mode, never a second source
            addrs.s1  = instruction[20:16];
            addrs.s2  = SREG_NONE;
            addrs.swb = instruction[25:21];
            addrs.v1  = instruction[19:16];
            addrs.v2  = VREG_NONE;
            addrs.vwb = instruction[24:21];

            if (instruction[30] == 1'b0) begin
                case (instruction[29:28])
                    2'b00, 2'b10: begin
                        addrs.v1  = VREG_NONE;
                        addrs.vwb = VREG_NONE;
                    end
                    2'b01: begin
                        case (instruction[27:26])
                            2'b00, 2'b01: begin
                                addrs.s1  = SREG_NONE;
                                addrs.vwb = VREG_NONE;
                            end
                            2'b10: begin
                                addrs.v1  = VREG_NONE;
                                addrs.vwb = VREG_NONE;
                            end
                            default: begin
                                // Vector source sits in the write-back field
                                addrs.v1  = instruction[24:21];
                                addrs.swb = SREG_NONE;
                            end
                        endcase
                    end
                    default: begin
                        // Loads, bit 27 picks the destination file
                        addrs.v1 = VREG_NONE;
                        if (instruction[27] == 1'b1) begin
                            addrs.swb = SREG_NONE;
                        end else begin
                            addrs.vwb = VREG_NONE;
                        end
                    end
                endcase
            end else begin
                // No write-back
                addrs.swb = SREG_NONE;
                addrs.vwb = VREG_NONE;
                addrs.s1  = SREG_NONE;
                addrs.v1  = VREG_NONE;

                // Stores, data register comes from bits 25:21
                if (instruction[29:28] == 2'b11) begin
                    addrs.s1 = instruction[20:16];
                    if (instruction[27:26] == 2'b11) begin
                        addrs.v1 = instruction[24:21];
                    end else begin
                        addrs.s2 = instruction[25:21];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/operand_pkg.sv ====
`default_nettype none

`include "decode_defines.svh"

package operand_pkg;

    import isa_pkg::*;

    // Operand data
    typedef logic [`XLEN-1:0] sdata_t;
    typedef logic [`VLEN-1:0] vdata_t;

    // Scalar write-back bus
    typedef struct packed {
        logic       en;
        sreg_addr_t addr;
        sdata_t     data;
    } sreg_write_s;

    // Vector write-back bus, all lanes at once
    typedef struct packed {
        logic       en;
        vreg_addr_t addr;
        vdata_t     data;
    } vreg_write_s;

    // Registered output of the decode stage
    typedef struct packed {
        logic          valid;
        operand_addr_s addrs;
        sdata_t        s1_data;
        sdata_t        s2_data;
        vdata_t        v1_data;
        vdata_t        v2_data;
    } decode_out_s;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

`include "decode_defines.svh"

package isa_pkg;

    // Raw instruction as fetched
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // Register addresses
    typedef logic [$clog2(`SREG_COUNT)-1:0] sreg_addr_t;
    typedef logic [$clog2(`VREG_COUNT)-1:0] vreg_addr_t;

    // Address 0 marks an unused operand or write-back
    localparam sreg_addr_t SREG_NONE = '0;
    localparam vreg_addr_t VREG_NONE = '0;

    // All six register addresses of one instruction
    typedef struct packed {
        sreg_addr_t s1;
        sreg_addr_t s2;
        sreg_addr_t swb;
        vreg_addr_t v1;
        vreg_addr_t v2;
        vreg_addr_t vwb;
    } operand_addr_s;

    // Instruction class fields, register mode
    //   bit 31      immediate mode
    //   bits 30:28  class
    //   bits 25:21  write-back
    //   bits 20:16  source 1
    //   bits 15:11  source 2
    // Immediate mode
    //   bit 30      no write-back
    //   bits 29:28  sub-class
    //   bits 27:26  variant

endpackage

`default_nettype wire

// ==== common/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Instruction word width
`define INSTR_WIDTH 32

// Register file depths
`define SREG_COUNT 32
`define VREG_COUNT 16

// Scalar word, also the width of one vector lane
`define XLEN 32

// Lanes per vector register
`define VLANES 4

// Full vector register width
`define VLEN (`VLANES * `XLEN)

// Register 0 is hardwired to zero in both files
// and doubles as "no register" in the decoded addresses

`endif
